// ==== logic/tomasulo_pkg.sv ====
package tomasulo_pkg;

   // Datapath and renaming widths shared by the dispatch stage.
   parameter int unsigned data_w     = 32;
   parameter int unsigned reg_addr_w = 5;
   parameter int unsigned tag_w      = 6;

   // One tag per in-flight result, so the free-tag FIFO starts out full.
   parameter int unsigned num_tags   = 64;

   // Primary opcodes of the supported MIPS subset, taken from bits 31:26.
   typedef enum logic [5:0] {
      op_rtype = 6'h00,
      op_j     = 6'h02,
      op_beq   = 6'h04,
      op_bne   = 6'h05,
      op_lw    = 6'h23,
      op_sw    = 6'h2b
   } opcode_e;

   // R-type function codes that leave the integer queue.
   // All other function codes travel to the integer queue unchanged.
   typedef enum logic [5:0] {
      fn_mult  = 6'h18,
      fn_multu = 6'h19,
      fn_div   = 6'h1a,
      fn_divu  = 6'h1b
   } funct_e;

   // Operation field of the load/store queue.
   typedef enum logic {
      ls_load  = 1'b0,
      ls_store = 1'b1
   } ls_op_e;

   // A branch holds dispatch in st_branch_stall until the CDB resolves it.
   typedef enum logic {
      st_dispatch     = 1'b0,
      st_branch_stall = 1'b1
   } dispatch_state_e;

endpackage

// ==== logic/cdb_if.sv ====
`timescale 1ns/10ps

interface cdb_if #(
   parameter int unsigned data_w = tomasulo_pkg::data_w,
   parameter int unsigned tag_w  = tomasulo_pkg::tag_w
);

   logic [tag_w-1:0]  tag;
   logic              valid;
   logic [data_w-1:0] data;
   logic              branch;
   logic              branch_taken;

   // The source of results drives the bus.
   modport producer (output tag, valid, data, branch, branch_taken);

   // Every storage block and the dispatch logic only observe it.
   modport listener (input tag, valid, data, branch, branch_taken);

endinterface

// ==== logic/register_file.sv ====
`timescale 1ns/10ps

module register_file #(
   parameter int unsigned data_w     = tomasulo_pkg::data_w,
   parameter int unsigned reg_addr_w = tomasulo_pkg::reg_addr_w
) (
   input  logic                         clk,
   input  logic                         rst_n,
   cdb_if.listener                      cdb,
   input  logic [(2**reg_addr_w)-1:0]   write_onehot,
   input  logic [reg_addr_w-1:0]        rs_addr,
   input  logic [reg_addr_w-1:0]        rt_addr,
   output logic [data_w-1:0]            rs_data,
   output logic [data_w-1:0]            rt_data,
   input  logic [reg_addr_w-1:0]        debug_addr,
   output logic [data_w-1:0]            debug_data
);

   localparam int unsigned num_regs = 2 ** reg_addr_w;

   logic [data_w-1:0] regs [num_regs];

   // The status table decides which registers take the CDB value, so
   // several registers waiting on the same tag are written together.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < num_regs; i++) begin
            regs[i] <= '0;
         end
      end else begin
         for (int i = 0; i < num_regs; i++) begin
            if (write_onehot[i]) begin
               regs[i] <= cdb.data;
            end
         end
      end
   end

   // Reads are combinational.
   // A value written this cycle is bypassed in the dispatch unit instead.
   assign rs_data    = regs[rs_addr];
   assign rt_data    = regs[rt_addr];
   assign debug_data = regs[debug_addr];

endmodule

// ==== logic/register_status_table.sv ====
`timescale 1ns/10ps

module register_status_table #(
   parameter int unsigned reg_addr_w = tomasulo_pkg::reg_addr_w,
   parameter int unsigned tag_w      = tomasulo_pkg::tag_w
) (
   input  logic                         clk,
   input  logic                         rst_n,
   cdb_if.listener                      cdb,
   input  logic [reg_addr_w-1:0]        rs_addr,
   input  logic [reg_addr_w-1:0]        rt_addr,
   output logic [tag_w-1:0]             rs_tag,
   output logic [tag_w-1:0]             rt_tag,
   output logic                         rs_busy,
   output logic                         rt_busy,
   input  logic                         claim_valid,
   input  logic [reg_addr_w-1:0]        claim_addr,
   input  logic [tag_w-1:0]             claim_tag,
   output logic [(2**reg_addr_w)-1:0]   write_onehot
);

   localparam int unsigned num_regs = 2 ** reg_addr_w;

   logic             busy [num_regs];
   logic [tag_w-1:0] tags [num_regs];

   // A register takes the CDB value only while it still waits for that tag.
   // An older producer whose tag was overwritten by a newer claim is ignored.
   always_comb begin
      for (int i = 0; i < num_regs; i++) begin
         write_onehot[i] = cdb.valid && busy[i] && (tags[i] == cdb.tag);
      end
   end

   assign rs_busy = busy[rs_addr];
   assign rt_busy = busy[rt_addr];
   assign rs_tag  = tags[rs_addr];
   assign rt_tag  = tags[rt_addr];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < num_regs; i++) begin
            busy[i] <= 1'b0;
            tags[i] <= '0;
         end
      end else begin
         for (int i = 0; i < num_regs; i++) begin
            // A new claim overrides a release in the same cycle.
            // Register 0 is never renamed so it always reads zero.
            if (claim_valid && (claim_addr == reg_addr_w'(i)) && (i != 0)) begin
               busy[i] <= 1'b1;
               tags[i] <= claim_tag;
            end else if (write_onehot[i]) begin
               busy[i] <= 1'b0;
            end
         end
      end
   end

endmodule

// ==== logic/tag_fifo.sv ====
`timescale 1ns/10ps

module tag_fifo #(
   parameter int unsigned tag_w    = tomasulo_pkg::tag_w,
   parameter int unsigned num_tags = tomasulo_pkg::num_tags
) (
   input  logic             clk,
   input  logic             rst_n,
   cdb_if.listener          cdb,
   input  logic             pop,
   output logic [tag_w-1:0] head_tag,
   output logic             empty,
   output logic             full
);

   localparam int unsigned ptr_w = (num_tags > 1) ? $clog2(num_tags) : 1;
   localparam int unsigned cnt_w = $clog2(num_tags + 1);

   logic [tag_w-1:0] mem [num_tags];
   logic [ptr_w-1:0] rd_ptr;
   logic [ptr_w-1:0] wr_ptr;
   logic [cnt_w-1:0] count;
   logic             do_pop;
   logic             do_push;

   // Pointers wrap explicitly so the depth need not be a power of two.
   function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
      return (ptr == ptr_w'(num_tags - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign empty    = (count == '0);
   assign full     = (count == cnt_w'(num_tags));
   assign head_tag = mem[rd_ptr];

   // Every result published on the CDB frees its tag.
   assign do_pop  = pop && !empty;
   assign do_push = cdb.valid && !full;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         // Start full, with tags handed out in ascending order.
         for (int i = 0; i < num_tags; i++) begin
            mem[i] <= tag_w'(i);
         end
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= cnt_w'(num_tags);
      end else begin
         if (do_push) begin
            mem[wr_ptr] <= cdb.tag;
            wr_ptr      <= next_ptr(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
      end
   end

endmodule

// ==== logic/dispatch_unit.sv ====
`timescale 1ns/10ps

module dispatch_unit #(
   parameter int unsigned data_w     = tomasulo_pkg::data_w,
   parameter int unsigned reg_addr_w = tomasulo_pkg::reg_addr_w,
   parameter int unsigned tag_w      = tomasulo_pkg::tag_w,
   parameter int unsigned num_tags   = tomasulo_pkg::num_tags
) (
   input  logic                   clk,
   input  logic                   rst_n,
   cdb_if.listener                cdb,
   input  logic [31:0]            ifq_inst,
   input  logic [data_w-1:0]      ifq_pc_plus4,
   input  logic                   ifq_empty,
   output logic                   ifq_ren,
   output logic [data_w-1:0]      ifq_branch_addr,
   output logic                   ifq_branch_valid,
   output logic [15:0]            queue_imm,
   output logic [tag_w-1:0]       queue_rd_tag,
   output logic [tag_w-1:0]       queue_rs_tag,
   output logic [tag_w-1:0]       queue_rt_tag,
   output logic [data_w-1:0]      queue_rs_data,
   output logic [data_w-1:0]      queue_rt_data,
   output logic                   queue_rs_ready,
   output logic                   queue_rt_ready,
   output logic [5:0]             int_opcode,
   output tomasulo_pkg::ls_op_e   ls_opcode,
   output logic                   int_en,
   output logic                   ls_en,
   output logic                   mult_en,
   output logic                   div_en,
   input  logic                   int_ready,
   input  logic                   ls_ready,
   input  logic                   mult_ready,
   input  logic                   div_ready,
   input  logic [reg_addr_w-1:0]  debug_addr,
   output logic [data_w-1:0]      debug_data
);

   import tomasulo_pkg::*;

   // Bit positions of the one-hot queue select.
   localparam int q_int  = 0;
   localparam int q_ls   = 1;
   localparam int q_mult = 2;
   localparam int q_div  = 3;

   dispatch_state_e state_q;
   dispatch_state_e state_d;

   opcode_e                 opcode;
   funct_e                  funct;
   logic [reg_addr_w-1:0]   inst_rs;
   logic [reg_addr_w-1:0]   inst_rt;
   logic [reg_addr_w-1:0]   inst_rd;
   logic [3:0]              q_sel;
   logic [3:0]              q_ready;
   logic                    need_tag;
   logic                    is_branch;
   logic                    is_jump;
   logic                    is_store;
   logic                    is_load;
   logic [reg_addr_w-1:0]   dest_addr;
   logic                    can_issue;
   logic                    resolve;
   logic                    go;
   logic [data_w-1:0]       branch_target;
   logic [data_w-1:0]       branch_target_q;
   logic [data_w-1:0]       jump_target;

   logic [(2**reg_addr_w)-1:0] write_onehot;
   logic [data_w-1:0]          rf_rs_data;
   logic [data_w-1:0]          rf_rt_data;
   logic [tag_w-1:0]           rs_tag;
   logic [tag_w-1:0]           rt_tag;
   logic                       rs_busy;
   logic                       rt_busy;
   logic                       rs_hit;
   logic                       rt_hit;
   logic [tag_w-1:0]           head_tag;
   logic                       tag_empty;

   assign opcode  = opcode_e'(ifq_inst[31:26]);
   assign funct   = funct_e'(ifq_inst[5:0]);
   assign inst_rs = ifq_inst[25:21];
   assign inst_rt = ifq_inst[20:16];
   assign inst_rd = ifq_inst[15:11];

   assign branch_target = ifq_pc_plus4 + {{(data_w-18){ifq_inst[15]}}, ifq_inst[15:0], 2'b00};
   assign jump_target   = {ifq_pc_plus4[data_w-1:28], ifq_inst[25:0], 2'b00};

   always_comb begin
      q_sel      = '0;
      need_tag   = 1'b0;
      is_branch  = 1'b0;
      is_jump    = 1'b0;
      is_store   = 1'b0;
      is_load    = 1'b0;
      dest_addr  = inst_rd;
      int_opcode = '0;
      ls_opcode  = ls_load;
      case (opcode)
         op_rtype: begin
            need_tag = 1'b1;
            case (funct)
               fn_mult, fn_multu: q_sel[q_mult] = 1'b1;
               fn_div, fn_divu:   q_sel[q_div]  = 1'b1;
               default: begin
                  q_sel[q_int] = 1'b1;
                  int_opcode   = ifq_inst[5:0];
               end
            endcase
         end
         op_beq, op_bne: begin
            q_sel[q_int] = 1'b1;
            int_opcode   = ifq_inst[31:26];
            is_branch    = 1'b1;
         end
         op_lw: begin
            q_sel[q_ls] = 1'b1;
            need_tag    = 1'b1;
            is_load     = 1'b1;
            dest_addr   = inst_rt;
         end
         op_sw: begin
            q_sel[q_ls] = 1'b1;
            ls_opcode   = ls_store;
            is_store    = 1'b1;
         end
         op_j:    is_jump = 1'b1;
         // Unknown opcodes select no queue and therefore never leave the head.
         default: q_sel = '0;
      endcase
   end

   assign q_ready   = {div_ready, mult_ready, ls_ready, int_ready};
   assign can_issue = |(q_sel & q_ready) && !ifq_empty && (!need_tag || !tag_empty);
   assign resolve   = cdb.valid && cdb.branch;

   // While stalled, the held instruction goes only on a not-taken resolution.
   assign go = (state_q == st_dispatch) ? can_issue
                                        : (can_issue && resolve && !cdb.branch_taken);

   assign ifq_ren = go;
   assign int_en  = go && q_sel[q_int];
   assign ls_en   = go && q_sel[q_ls];
   assign mult_en = go && q_sel[q_mult];
   assign div_en  = go && q_sel[q_div];

   // Jumps redirect at once. Taken branches redirect to the captured target.
   assign ifq_branch_valid = (state_q == st_dispatch) ? (is_jump && !ifq_empty)
                                                      : (resolve && cdb.branch_taken);
   assign ifq_branch_addr  = (state_q == st_dispatch) ? jump_target : branch_target_q;

   always_comb begin
      state_d = state_q;
      if (go && is_branch) begin
         state_d = st_branch_stall;
      end else if (resolve) begin
         state_d = st_dispatch;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= st_dispatch;
      end else begin
         state_q <= state_d;
      end
   end

   always_ff @(posedge clk) begin
      if (go && is_branch) begin
         branch_target_q <= branch_target;
      end
   end

   // A result on the CDB this cycle completes a pending operand right away.
   assign rs_hit = cdb.valid && rs_busy && (rs_tag == cdb.tag);
   assign rt_hit = cdb.valid && rt_busy && (rt_tag == cdb.tag);

   assign queue_imm      = ifq_inst[15:0];
   assign queue_rd_tag   = head_tag;
   assign queue_rs_tag   = rs_tag;
   assign queue_rt_tag   = is_load ? head_tag : rt_tag;
   assign queue_rs_ready = !rs_busy || rs_hit;
   assign queue_rt_ready = is_store || !rt_busy || rt_hit;
   assign queue_rs_data  = rs_hit ? cdb.data : rf_rs_data;
   assign queue_rt_data  = rt_hit ? cdb.data : rf_rt_data;

   register_file #(
      .data_w     (data_w),
      .reg_addr_w (reg_addr_w)
   ) u_register_file (
      .clk          (clk),
      .rst_n        (rst_n),
      .cdb          (cdb),
      .write_onehot (write_onehot),
      .rs_addr      (inst_rs),
      .rt_addr      (inst_rt),
      .rs_data      (rf_rs_data),
      .rt_data      (rf_rt_data),
      .debug_addr   (debug_addr),
      .debug_data   (debug_data)
   );

   register_status_table #(
      .reg_addr_w (reg_addr_w),
      .tag_w      (tag_w)
   ) u_register_status_table (
      .clk          (clk),
      .rst_n        (rst_n),
      .cdb          (cdb),
      .rs_addr      (inst_rs),
      .rt_addr      (inst_rt),
      .rs_tag       (rs_tag),
      .rt_tag       (rt_tag),
      .rs_busy      (rs_busy),
      .rt_busy      (rt_busy),
      .claim_valid  (go && need_tag),
      .claim_addr   (dest_addr),
      .claim_tag    (head_tag),
      .write_onehot (write_onehot)
   );

   tag_fifo #(
      .tag_w    (tag_w),
      .num_tags (num_tags)
   ) u_tag_fifo (
      .clk      (clk),
      .rst_n    (rst_n),
      .cdb      (cdb),
      .pop      (go && need_tag),
      .head_tag (head_tag),
      .empty    (tag_empty),
      .full     ()
   );

endmodule

// ==== logic/dispatch_top.sv ====
`timescale 1ns/10ps

module dispatch_top #(
   parameter int unsigned data_w     = tomasulo_pkg::data_w,
   parameter int unsigned reg_addr_w = tomasulo_pkg::reg_addr_w,
   parameter int unsigned tag_w      = tomasulo_pkg::tag_w,
   parameter int unsigned num_tags   = tomasulo_pkg::num_tags
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic [31:0]            ifq_inst,
   input  logic [data_w-1:0]      ifq_pc_plus4,
   input  logic                   ifq_empty,
   output logic                   ifq_ren,
   output logic [data_w-1:0]      ifq_branch_addr,
   output logic                   ifq_branch_valid,
   output logic [15:0]            queue_imm,
   output logic [tag_w-1:0]       queue_rd_tag,
   output logic [tag_w-1:0]       queue_rs_tag,
   output logic [tag_w-1:0]       queue_rt_tag,
   output logic [data_w-1:0]      queue_rs_data,
   output logic [data_w-1:0]      queue_rt_data,
   output logic                   queue_rs_ready,
   output logic                   queue_rt_ready,
   output logic [5:0]             int_opcode,
   output tomasulo_pkg::ls_op_e   ls_opcode,
   output logic                   int_en,
   output logic                   ls_en,
   output logic                   mult_en,
   output logic                   div_en,
   input  logic                   int_ready,
   input  logic                   ls_ready,
   input  logic                   mult_ready,
   input  logic                   div_ready,
   input  logic [reg_addr_w-1:0]  debug_addr,
   output logic [data_w-1:0]      debug_data,
   input  logic [tag_w-1:0]       cdb_tag,
   input  logic                   cdb_valid,
   input  logic [data_w-1:0]      cdb_data,
   input  logic                   cdb_branch,
   input  logic                   cdb_branch_taken
);

   cdb_if #(
      .data_w (data_w),
      .tag_w  (tag_w)
   ) u_cdb ();

   // The external result source is the only producer on the bus.
   assign u_cdb.tag          = cdb_tag;
   assign u_cdb.valid        = cdb_valid;
   assign u_cdb.data         = cdb_data;
   assign u_cdb.branch       = cdb_branch;
   assign u_cdb.branch_taken = cdb_branch_taken;

   dispatch_unit #(
      .data_w     (data_w),
      .reg_addr_w (reg_addr_w),
      .tag_w      (tag_w),
      .num_tags   (num_tags)
   ) u_dispatch_unit (
      .clk              (clk),
      .rst_n            (rst_n),
      .cdb              (u_cdb.listener),
      .ifq_inst         (ifq_inst),
      .ifq_pc_plus4     (ifq_pc_plus4),
      .ifq_empty        (ifq_empty),
      .ifq_ren          (ifq_ren),
      .ifq_branch_addr  (ifq_branch_addr),
      .ifq_branch_valid (ifq_branch_valid),
      .queue_imm        (queue_imm),
      .queue_rd_tag     (queue_rd_tag),
      .queue_rs_tag     (queue_rs_tag),
      .queue_rt_tag     (queue_rt_tag),
      .queue_rs_data    (queue_rs_data),
      .queue_rt_data    (queue_rt_data),
      .queue_rs_ready   (queue_rs_ready),
      .queue_rt_ready   (queue_rt_ready),
      .int_opcode       (int_opcode),
      .ls_opcode        (ls_opcode),
      .int_en           (int_en),
      .ls_en            (ls_en),
      .mult_en          (mult_en),
      .div_en           (div_en),
      .int_ready        (int_ready),
      .ls_ready         (ls_ready),
      .mult_ready       (mult_ready),
      .div_ready        (div_ready),
      .debug_addr       (debug_addr),
      .debug_data       (debug_data)
   );

endmodule

// ==== tb/dispatch_tb.sv ====
`timescale 1ns/10ps

module dispatch_tb;

   import tomasulo_pkg::*;

   localparam int clk_period   = 40;
   localparam int sample_delay = 10;
   localparam int q_int        = 0;
   localparam int q_ls         = 1;
   localparam int q_mult       = 2;
   localparam int q_div        = 3;
   localparam logic [5:0] fn_add = 6'h20;

   logic                  clk;
   logic                  rst_n;
   logic [31:0]           ifq_inst;
   logic [data_w-1:0]     ifq_pc_plus4;
   logic                  ifq_empty;
   logic                  ifq_ren;
   logic [data_w-1:0]     ifq_branch_addr;
   logic                  ifq_branch_valid;
   logic [15:0]           queue_imm;
   logic [tag_w-1:0]      queue_rd_tag;
   logic [tag_w-1:0]      queue_rs_tag;
   logic [tag_w-1:0]      queue_rt_tag;
   logic [data_w-1:0]     queue_rs_data;
   logic [data_w-1:0]     queue_rt_data;
   logic                  queue_rs_ready;
   logic                  queue_rt_ready;
   logic [5:0]            int_opcode;
   ls_op_e                ls_opcode;
   logic                  int_en;
   logic                  ls_en;
   logic                  mult_en;
   logic                  div_en;
   logic                  int_ready;
   logic                  ls_ready;
   logic                  mult_ready;
   logic                  div_ready;
   logic [reg_addr_w-1:0] debug_addr;
   logic [data_w-1:0]     debug_data;
   logic [tag_w-1:0]      cdb_tag;
   logic                  cdb_valid;
   logic [data_w-1:0]     cdb_data;
   logic                  cdb_branch;
   logic                  cdb_branch_taken;

   // Reference model of the free tags, the registers and their renaming.
   logic [tag_w-1:0]  free_tags [$];
   logic [data_w-1:0] model_regs [32];
   logic              model_busy [32];
   logic [tag_w-1:0]  model_tag [32];
   logic              pend_claim;
   logic [4:0]        pend_dest;
   logic [31:0]       fetch_pc;
   logic [31:0]       rng_state = 32'hc2a1_b1fd;
   int                errors;
   int                checks;

   dispatch_top u_dut (.*);

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   function automatic logic [31:0] xorshift32();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic logic [31:0] r_inst(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [5:0] fn);
      return {6'h00, rs, rt, rd, 5'd0, fn};
   endfunction

   function automatic logic [31:0] i_inst(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   task automatic check(input string name, input logic [31:0] actual,
                        input logic [31:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
      end
   endtask

   task automatic finish_run();
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   endtask

   task automatic check_enables_low();
      check("ifq_ren", ifq_ren, 0);
      check("int_en", int_en, 0);
      check("ls_en", ls_en, 0);
      check("mult_en", mult_en, 0);
      check("div_en", div_en, 0);
   endtask

   task automatic check_idle();
      check_enables_low();
      check("ifq_branch_valid", ifq_branch_valid, 0);
   endtask

   task automatic check_redirect(input logic [31:0] addr);
      check_enables_low();
      check("ifq_branch_valid", ifq_branch_valid, 1);
      check("ifq_branch_addr", ifq_branch_addr, addr);
   endtask

   task automatic drive_cdb(input logic [5:0] tag, input logic [31:0] data,
                            input logic branch, input logic taken);
      cdb_valid        = 1'b1;
      cdb_tag          = tag;
      cdb_data         = data;
      cdb_branch       = branch;
      cdb_branch_taken = taken;
   endtask

   // Apply the effects of the coming clock edge to the model, then move to
   // the next falling edge with the CDB idle.
   task automatic advance();
      if (cdb_valid) begin
         for (int r = 0; r < 32; r++) begin
            if (model_busy[r] && (model_tag[r] == cdb_tag)) begin
               model_regs[r] = cdb_data;
               model_busy[r] = 1'b0;
            end
         end
         if (free_tags.size() < num_tags) free_tags.push_back(cdb_tag);
      end
      if (pend_claim) begin
         if (pend_dest != 0) begin
            model_busy[pend_dest] = 1'b1;
            model_tag[pend_dest]  = free_tags[0];
         end
         void'(free_tags.pop_front());
      end
      pend_claim = 1'b0;
      @(negedge clk);
      cdb_valid        = 1'b0;
      cdb_branch       = 1'b0;
      cdb_branch_taken = 1'b0;
   endtask

   task automatic check_operand(input string name, input logic [4:0] r, input logic ready,
                                input logic [5:0] tag, input logic [31:0] data);
      logic hit;
      hit = cdb_valid && model_busy[r] && (model_tag[r] == cdb_tag);
      if (model_busy[r] && !hit) begin
         check({name, "_ready"}, ready, 0);
         check({name, "_tag"}, tag, model_tag[r]);
      end else begin
         check({name, "_ready"}, ready, 1);
         check({name, "_data"}, data, hit ? cdb_data : model_regs[r]);
      end
   endtask

   task automatic expect_dispatch(input logic [31:0] inst, input int q);
      logic [5:0] op;
      logic [4:0] rt;
      op = inst[31:26];
      rt = inst[20:16];
      check("ifq_ren", ifq_ren, 1);
      check("int_en", int_en, q == q_int);
      check("ls_en", ls_en, q == q_ls);
      check("mult_en", mult_en, q == q_mult);
      check("div_en", div_en, q == q_div);
      check("ifq_branch_valid", ifq_branch_valid, 0);
      check("queue_imm", queue_imm, inst[15:0]);
      if (q == q_int) check("int_opcode", int_opcode, (op == 6'h00) ? inst[5:0] : op);
      if (q == q_ls) check("ls_opcode", ls_opcode, (op == op_sw) ? ls_store : ls_load);
      check_operand("queue_rs", inst[25:21], queue_rs_ready, queue_rs_tag, queue_rs_data);
      if (op == op_sw) begin
         check("queue_rt_ready", queue_rt_ready, 1);
      end else if (op != op_lw) begin
         check_operand("queue_rt", rt, queue_rt_ready, queue_rt_tag, queue_rt_data);
      end
      // R-types write rd and loads write rt, each under a fresh tag.
      pend_claim = (op == op_rtype) || (op == op_lw);
      pend_dest  = (op == op_lw) ? rt : inst[15:11];
      if (pend_claim) check("queue_rd_tag", queue_rd_tag, free_tags[0]);
      if (op == op_lw) check("queue_rt_tag", queue_rt_tag, free_tags[0]);
   endtask

   task automatic wait_for_ren(input int limit);
      int waited;
      waited = 0;
      #sample_delay;
      while (!ifq_ren && (waited < limit)) begin
         check_idle();
         advance();
         #sample_delay;
         waited++;
      end
      if (!ifq_ren) begin
         errors++;
         $display("timeout: head instruction not dispatched within %0d cycles", limit);
         finish_run();
      end
   endtask

   task automatic expect_held(input int cycles);
      repeat (cycles) begin
         #sample_delay;
         check_idle();
         advance();
      end
   endtask

   task automatic present(input logic [31:0] inst);
      ifq_inst     = inst;
      ifq_pc_plus4 = fetch_pc + 4;
      ifq_empty    = 1'b0;
   endtask

   // Present one instruction that must leave the head in the same cycle.
   task automatic send(input logic [31:0] inst, input int q);
      present(inst);
      wait_for_ren(0);
      expect_dispatch(inst, q);
      advance();
      ifq_empty = 1'b1;
      fetch_pc  = fetch_pc + 4;
   endtask

   task automatic publish(input logic [5:0] tag, input logic [31:0] data);
      drive_cdb(tag, data, 1'b0, 1'b0);
      #sample_delay;
      advance();
   endtask

   task automatic refill_tags();
      logic [5:0] missing [$];
      logic       found;
      for (int t = 0; t < num_tags; t++) begin
         found = 1'b0;
         foreach (free_tags[i]) begin
            if (free_tags[i] == t) found = 1'b1;
         end
         if (!found) missing.push_back(tag_w'(t));
      end
      foreach (missing[i]) publish(missing[i], xorshift32());
   endtask

   task automatic test_reset_dispatch();
      #sample_delay;
      check_idle();
      advance();
      send(r_inst(1, 2, 3, fn_add), q_int);
      send(r_inst(1, 2, 4, fn_add), q_int);
      send(r_inst(2, 1, 5, fn_add), q_int);
   endtask

   task automatic test_dependency();
      logic [31:0] d;
      logic [5:0]  t;
      send(r_inst(3, 1, 6, fn_add), q_int);
      // The CDB result for r4 arrives in the same cycle as its reader.
      d = xorshift32();
      drive_cdb(model_tag[4], d, 1'b0, 1'b0);
      send(r_inst(4, 0, 7, fn_add), q_int);
      debug_addr = 5'd4;
      #sample_delay;
      check("debug_data", debug_data, d);
      advance();
      send(r_inst(4, 4, 8, fn_add), q_int);
      t = free_tags[0];
      send(r_inst(1, 2, 0, fn_add), q_int);
      debug_addr = 5'd0;
      publish(t, xorshift32());
      #sample_delay;
      check("debug_data", debug_data, 0);
      advance();
      send(r_inst(0, 0, 9, fn_add), q_int);
   endtask

   task automatic test_routing();
      logic [31:0] r;
      send(r_inst(1, 2, 11, fn_mult), q_mult);
      send(r_inst(2, 3, 11, fn_multu), q_mult);
      send(r_inst(3, 4, 11, fn_div), q_div);
      send(r_inst(4, 5, 11, fn_divu), q_div);
      r = xorshift32();
      send(i_inst(op_lw, 1, 12, r[15:0]), q_ls);
      r = xorshift32();
      send(i_inst(op_sw, 1, 12, r[15:0]), q_ls);
      send(r_inst(12, 0, 13, fn_add), q_int);
   endtask

   task automatic test_backpressure();
      logic [31:0] inst;
      logic [5:0]  t;
      inst = r_inst(1, 2, 14, fn_add);
      int_ready = 1'b0;
      present(inst);
      expect_held(3);
      int_ready = 1'b1;
      wait_for_ren(2);
      expect_dispatch(inst, q_int);
      advance();
      present(inst);
      ifq_empty = 1'b1;
      expect_held(3);
      ifq_empty = 1'b0;
      wait_for_ren(2);
      expect_dispatch(inst, q_int);
      advance();
      ifq_empty = 1'b1;
      // Use up every tag, then return one while the add waits at the head.
      while (free_tags.size() > 0) send(r_inst(0, 0, 10, fn_add), q_int);
      present(inst);
      expect_held(3);
      t = model_tag[10];
      drive_cdb(t, xorshift32(), 1'b0, 1'b0);
      #sample_delay;
      check_idle();
      advance();
      wait_for_ren(2);
      check("queue_rd_tag", queue_rd_tag, t);
      expect_dispatch(inst, q_int);
      advance();
      ifq_empty = 1'b1;
      refill_tags();
   endtask

   task automatic test_branch_not_taken();
      logic [31:0] r;
      logic [31:0] inst;
      r = xorshift32();
      send(i_inst(op_beq, 1, 2, r[15:0]), q_int);
      inst = r_inst(1, 2, 15, fn_add);
      present(inst);
      expect_held(2);
      drive_cdb(6'd0, 32'd0, 1'b1, 1'b0);
      wait_for_ren(0);
      expect_dispatch(inst, q_int);
      advance();
      ifq_empty = 1'b1;
   endtask

   task automatic test_branch_taken_and_jump();
      logic [31:0] r;
      logic [15:0] off;
      logic [25:0] target;
      logic [31:0] exp_addr;
      r = xorshift32();
      fetch_pc = {r[31:2], 2'b00};
      r = xorshift32();
      off = r[15:0];
      exp_addr = fetch_pc + 4 + {{14{off[15]}}, off, 2'b00};
      send(i_inst(op_bne, 2, 3, off), q_int);
      present(r_inst(1, 2, 16, fn_add));
      expect_held(1);
      drive_cdb(6'd0, 32'd0, 1'b1, 1'b1);
      #sample_delay;
      check_redirect(exp_addr);
      advance();
      ifq_empty = 1'b1;
      expect_held(1);
      // The jump target keeps the upper PC bits and the 26-bit word index.
      r = xorshift32();
      fetch_pc = {r[31:2], 2'b00};
      r = xorshift32();
      target = r[25:0];
      present({op_j, target});
      #sample_delay;
      check_redirect({ifq_pc_plus4[31:28], target, 2'b00});
      advance();
      ifq_empty = 1'b1;
      send(r_inst(3, 4, 17, fn_add), q_int);
   endtask

   initial begin
      rst_n            = 1'b0;
      ifq_inst         = '0;
      ifq_pc_plus4     = '0;
      ifq_empty        = 1'b1;
      int_ready        = 1'b1;
      ls_ready         = 1'b1;
      mult_ready       = 1'b1;
      div_ready        = 1'b1;
      debug_addr       = '0;
      cdb_tag          = '0;
      cdb_valid        = 1'b0;
      cdb_data         = '0;
      cdb_branch       = 1'b0;
      cdb_branch_taken = 1'b0;
      pend_claim       = 1'b0;
      pend_dest        = '0;
      fetch_pc         = 32'h0040_0000;
      errors           = 0;
      checks           = 0;
      for (int i = 0; i < num_tags; i++) begin
         free_tags.push_back(tag_w'(i));
      end
      for (int r = 0; r < 32; r++) begin
         model_regs[r] = '0;
         model_busy[r] = 1'b0;
         model_tag[r]  = '0;
      end
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      test_reset_dispatch();
      test_dependency();
      test_routing();
      test_backpressure();
      test_branch_not_taken();
      test_branch_taken_and_jump();
      finish_run();
   end

endmodule

// ==== sim.f ====
logic/tomasulo_pkg.sv
logic/cdb_if.sv
logic/register_file.sv
logic/register_status_table.sv
logic/tag_fifo.sv
logic/dispatch_unit.sv
logic/dispatch_top.sv
tb/dispatch_tb.sv

// ==== Makefile ====
TOP = dispatch_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f sim.f -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "Simulation passed"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir
